// ==== verilog/iopmp_params.svh ====
`ifndef IOPMP_PARAMS_SVH
`define IOPMP_PARAMS_SVH

// table sizes
`define IOPMP_ENTRIES 4
`define IOPMP_MDS 2
`define IOPMP_RRIDS 2

// register map
`define OFS_VERSION 16'h0000
`define OFS_IMPL 16'h0004
`define OFS_HWCFG0 16'h0008
`define OFS_HWCFG1 16'h000C
`define OFS_HWCFG2 16'h0010
`define OFS_ENTRYOFFSET 16'h0014
`define OFS_MDCFGLCK 16'h0048
`define OFS_ENTRYLCK 16'h004C
`define OFS_MDCFG 16'h0800
`define OFS_SRCMD 16'h1000
`define OFS_ENTRY 16'h2000

// per-index strides of the tables
`define MDCFG_STRIDE 4
`define SRCMD_STRIDE 32
`define ENTRY_STRIDE 16
`define ENTRY_CFG_SUB 8

// identity
`define IOPMP_VENDOR 24'hABCD
`define IOPMP_IMPID 32'hFFFF_FFFF
`define IOPMP_MODEL 4'd0

`endif

// ==== verilog/iopmp_tl_pkg.sv ====
`include "iopmp_params.svh"

package iopmp_tl_pkg;

  //////////////////////////////
  // bus side of the register port
  //////////////////////////////

  typedef logic [15:0] tl_addr_t;
  typedef logic [31:0] tl_data_t;
  typedef logic [7:0] tl_source_t;

  // A channel, full-word writes and reads only
  typedef enum logic [2:0] {
    PutFullData = 3'd0,
    Get         = 3'd4
  } tl_a_op_e;

  typedef enum logic [2:0] {
    AccessAck     = 3'd0,
    AccessAckData = 3'd1
  } tl_d_op_e;

endpackage

// ==== verilog/iopmp_reg_pkg.sv ====
`include "iopmp_params.svh"

package iopmp_reg_pkg;

  //////////////////////////////
  // decoded register targets
  //////////////////////////////

  typedef enum logic [3:0] {
    SEL_NONE,
    SEL_VERSION,
    SEL_IMPL,
    SEL_HWCFG0,
    SEL_HWCFG1,
    SEL_HWCFG2,
    SEL_ENTRYOFFSET,
    SEL_MDCFGLCK,
    SEL_ENTRYLCK,
    SEL_MDCFG,
    SEL_SRCMD,
    SEL_ENTRY_ADDR,
    SEL_ENTRY_CFG
  } reg_sel_e;

  typedef logic [7:0] tbl_idx_t;
  // entry count, also used for top-of-domain
  typedef logic [15:0] entry_num_t;
  typedef logic [10:0] entry_cfg_t;
  typedef logic [30:0] md_mask_t;

  typedef enum logic {IDLE, RESP} resp_state_e;

endpackage

// ==== verilog/iopmp_reg_if.sv ====
interface reg_access_if;
  import iopmp_tl_pkg::*;
  import iopmp_reg_pkg::*;

  // one accepted request, already decoded
  logic access;
  logic write;
  reg_sel_e sel;
  tbl_idx_t idx;
  tl_data_t wdata;

  modport dec (output access, output write, output sel, output idx, output wdata);

  modport bank (input access, input write, input sel, input idx, input wdata);

endinterface

// ==== verilog/iopmp_addr_decoder.sv ====
`include "iopmp_params.svh"

module iopmp_addr_decoder (
  input  logic                   a_valid_i,
  input  iopmp_tl_pkg::tl_a_op_e a_opcode_i,
  input  iopmp_tl_pkg::tl_addr_t a_address_i,
  input  iopmp_tl_pkg::tl_data_t a_data_i,
  input  logic                   a_ready_i,
  reg_access_if.dec              acc
);
  import iopmp_tl_pkg::*;
  import iopmp_reg_pkg::*;

  // handshake on the A channel
  assign acc.access = a_valid_i & a_ready_i;
  assign acc.write = (a_opcode_i == PutFullData);
  assign acc.wdata = a_data_i;

  //////////////////////////////
  // address to target and index
  //////////////////////////////

  always_comb begin
    acc.sel = SEL_NONE;
    acc.idx = '0;
    case (a_address_i)
      `OFS_VERSION: acc.sel = SEL_VERSION;
      `OFS_IMPL: acc.sel = SEL_IMPL;
      `OFS_HWCFG0: acc.sel = SEL_HWCFG0;
      `OFS_HWCFG1: acc.sel = SEL_HWCFG1;
      `OFS_HWCFG2: acc.sel = SEL_HWCFG2;
      `OFS_ENTRYOFFSET: acc.sel = SEL_ENTRYOFFSET;
      `OFS_MDCFGLCK: acc.sel = SEL_MDCFGLCK;
      `OFS_ENTRYLCK: acc.sel = SEL_ENTRYLCK;
      default: begin
        // table slots, anything else stays unmapped
        for (int j = 0; j < `IOPMP_MDS; j++) begin
          if (a_address_i == tl_addr_t'(`OFS_MDCFG + j * `MDCFG_STRIDE)) begin
            acc.sel = SEL_MDCFG;
            acc.idx = tbl_idx_t'(j);
          end
        end
        for (int j = 0; j < `IOPMP_RRIDS; j++) begin
          if (a_address_i == tl_addr_t'(`OFS_SRCMD + j * `SRCMD_STRIDE)) begin
            acc.sel = SEL_SRCMD;
            acc.idx = tbl_idx_t'(j);
          end
        end
        for (int i = 0; i < `IOPMP_ENTRIES; i++) begin
          if (a_address_i == tl_addr_t'(`OFS_ENTRY + i * `ENTRY_STRIDE)) begin
            acc.sel = SEL_ENTRY_ADDR;
            acc.idx = tbl_idx_t'(i);
          end
          if (a_address_i ==
              tl_addr_t'(`OFS_ENTRY + i * `ENTRY_STRIDE + `ENTRY_CFG_SUB)) begin
            acc.sel = SEL_ENTRY_CFG;
            acc.idx = tbl_idx_t'(i);
          end
        end
      end
    endcase
  end

endmodule

// ==== verilog/iopmp_cfg_regs.sv ====
`include "iopmp_params.svh"

module iopmp_cfg_regs (
  input  logic                       clk,
  input  logic                       reset,
  reg_access_if.bank                 acc,
  output iopmp_tl_pkg::tl_data_t     cfg_rdata_o,
  output iopmp_reg_pkg::entry_num_t  mdcfglck_f_o,
  output iopmp_reg_pkg::entry_num_t  entrylck_f_o,
  output iopmp_reg_pkg::entry_num_t  prio_entry_o,
  output logic                       enable_o
);
  import iopmp_reg_pkg::*;

  logic wr;
  logic enable_q;
  logic prient_prog_q;
  entry_num_t prio_entry_q;
  logic mdcfglck_l_q;
  logic [6:0] mdcfglck_f_q;
  logic entrylck_l_q;
  entry_num_t entrylck_f_q;
  entry_num_t new_prio;
  entry_num_t new_elck_f;

  assign wr = acc.access & acc.write;
  assign new_prio = acc.wdata[15:0];
  assign new_elck_f = acc.wdata[16:1];

  //////////////////////////////
  // write rules
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      enable_q <= 1'b0;
      prient_prog_q <= 1'b1;
      prio_entry_q <= '0;
      mdcfglck_l_q <= 1'b0;
      mdcfglck_f_q <= '0;
      entrylck_l_q <= 1'b0;
      entrylck_f_q <= '0;
    end else if (wr) begin
      case (acc.sel)
        SEL_HWCFG0: begin
          // both bits only ever move one way
          if (acc.wdata[31]) enable_q <= 1'b1;
          if (acc.wdata[7]) prient_prog_q <= 1'b0;
        end
        SEL_HWCFG2: begin
          if (prient_prog_q && new_prio < entry_num_t'(`IOPMP_ENTRIES)) begin
            prio_entry_q <= new_prio;
          end
        end
        SEL_MDCFGLCK: begin
          if (acc.wdata[0]) mdcfglck_l_q <= 1'b1;
          if (!mdcfglck_l_q) mdcfglck_f_q <= acc.wdata[7:1];
        end
        SEL_ENTRYLCK: begin
          if (acc.wdata[0]) entrylck_l_q <= 1'b1;
          // lock boundary only grows, capped at the entry count
          if (!entrylck_l_q && new_elck_f >= entrylck_f_q &&
              new_elck_f <= entry_num_t'(`IOPMP_ENTRIES)) begin
            entrylck_f_q <= new_elck_f;
          end
        end
        default: ;
      endcase
    end
  end

  // read mux, zero when another bank owns sel
  always_comb begin
    cfg_rdata_o = '0;
    case (acc.sel)
      SEL_VERSION: cfg_rdata_o[23:0] = `IOPMP_VENDOR;
      SEL_IMPL: cfg_rdata_o = `IOPMP_IMPID;
      SEL_HWCFG0: begin
        cfg_rdata_o[3:0] = `IOPMP_MODEL;
        cfg_rdata_o[4] = 1'b1;
        cfg_rdata_o[7] = prient_prog_q;
        cfg_rdata_o[30:24] = 7'(`IOPMP_MDS);
        cfg_rdata_o[31] = enable_q;
      end
      SEL_HWCFG1: cfg_rdata_o = {16'(`IOPMP_ENTRIES), 16'(`IOPMP_RRIDS)};
      SEL_HWCFG2: cfg_rdata_o[15:0] = prio_entry_q;
      SEL_ENTRYOFFSET: cfg_rdata_o = 32'(`OFS_ENTRY);
      SEL_MDCFGLCK: cfg_rdata_o[7:0] = {mdcfglck_f_q, mdcfglck_l_q};
      SEL_ENTRYLCK: cfg_rdata_o[16:0] = {entrylck_f_q, entrylck_l_q};
      default: ;
    endcase
  end

  assign mdcfglck_f_o = entry_num_t'(mdcfglck_f_q);
  assign entrylck_f_o = entrylck_f_q;
  assign prio_entry_o = prio_entry_q;
  assign enable_o = enable_q;

endmodule

// ==== verilog/iopmp_table_regs.sv ====
`include "iopmp_params.svh"

module iopmp_table_regs (
  input  logic                       clk,
  input  logic                       reset,
  reg_access_if.bank                 acc,
  input  iopmp_reg_pkg::entry_num_t  mdcfglck_f_i,
  input  iopmp_reg_pkg::entry_num_t  entrylck_f_i,
  output iopmp_tl_pkg::tl_data_t     tbl_rdata_o,
  output iopmp_tl_pkg::tl_data_t     entry_addr_o [`IOPMP_ENTRIES],
  output iopmp_reg_pkg::entry_cfg_t  entry_cfg_o [`IOPMP_ENTRIES],
  output iopmp_reg_pkg::entry_num_t  mdcfg_o [`IOPMP_MDS],
  output iopmp_tl_pkg::tl_data_t     srcmd_en_o [`IOPMP_RRIDS]
);
  import iopmp_tl_pkg::*;
  import iopmp_reg_pkg::*;

  logic wr;
  entry_num_t wr_top;
  entry_num_t mdcfg_q [`IOPMP_MDS];
  logic srcmd_l_q [`IOPMP_RRIDS];
  md_mask_t srcmd_md_q [`IOPMP_RRIDS];
  tl_data_t entry_addr_q [`IOPMP_ENTRIES];
  entry_cfg_t entry_cfg_q [`IOPMP_ENTRIES];

  assign wr = acc.access & acc.write;
  assign wr_top = acc.wdata[15:0];

  //////////////////////////////
  // MDCFG
  //////////////////////////////

  for (genvar j = 0; j < `IOPMP_MDS; j++) begin : g_mdcfg
    logic hit;
    logic in_order;

    assign hit = wr && acc.sel == SEL_MDCFG && acc.idx == tbl_idx_t'(j);
    // top of domain never below the previous one
    if (j == 0) begin : g_first
      assign in_order = 1'b1;
    end else begin : g_next
      assign in_order = (wr_top >= mdcfg_q[j-1]);
    end

    always_ff @(posedge clk) begin
      if (reset) begin
        mdcfg_q[j] <= '0;
      end else if (hit && entry_num_t'(j) >= mdcfglck_f_i && in_order &&
                   wr_top <= entry_num_t'(`IOPMP_ENTRIES)) begin
        mdcfg_q[j] <= wr_top;
      end
    end
    assign mdcfg_o[j] = mdcfg_q[j];
  end

  // SRCMD_EN, bit 0 locks the membership bits
  for (genvar j = 0; j < `IOPMP_RRIDS; j++) begin : g_srcmd
    always_ff @(posedge clk) begin
      if (reset) begin
        srcmd_l_q[j] <= 1'b0;
        srcmd_md_q[j] <= '0;
      end else if (wr && acc.sel == SEL_SRCMD && acc.idx == tbl_idx_t'(j)) begin
        if (acc.wdata[0]) srcmd_l_q[j] <= 1'b1;
        if (!srcmd_l_q[j]) srcmd_md_q[j] <= acc.wdata[31:1];
      end
    end
    assign srcmd_en_o[j] = {srcmd_md_q[j], srcmd_l_q[j]};
  end

  // entries below entrylck_f are frozen
  for (genvar i = 0; i < `IOPMP_ENTRIES; i++) begin : g_entry
    logic unlocked;

    assign unlocked = wr && acc.idx == tbl_idx_t'(i) && entry_num_t'(i) >= entrylck_f_i;

    always_ff @(posedge clk) begin
      if (reset) begin
        entry_addr_q[i] <= '0;
        entry_cfg_q[i] <= '0;
      end else if (unlocked) begin
        if (acc.sel == SEL_ENTRY_ADDR) entry_addr_q[i] <= acc.wdata;
        if (acc.sel == SEL_ENTRY_CFG) entry_cfg_q[i] <= acc.wdata[10:0];
      end
    end
    assign entry_addr_o[i] = entry_addr_q[i];
    assign entry_cfg_o[i] = entry_cfg_q[i];
  end

  //////////////////////////////
  // read mux
  //////////////////////////////

  always_comb begin
    tbl_rdata_o = '0;
    for (int j = 0; j < `IOPMP_MDS; j++) begin
      if (acc.sel == SEL_MDCFG && acc.idx == tbl_idx_t'(j)) begin
        tbl_rdata_o = {16'h0, mdcfg_q[j]};
      end
    end
    for (int j = 0; j < `IOPMP_RRIDS; j++) begin
      if (acc.sel == SEL_SRCMD && acc.idx == tbl_idx_t'(j)) begin
        tbl_rdata_o = {srcmd_md_q[j], srcmd_l_q[j]};
      end
    end
    for (int i = 0; i < `IOPMP_ENTRIES; i++) begin
      if (acc.idx == tbl_idx_t'(i)) begin
        if (acc.sel == SEL_ENTRY_ADDR) tbl_rdata_o = entry_addr_q[i];
        if (acc.sel == SEL_ENTRY_CFG) tbl_rdata_o = {21'h0, entry_cfg_q[i]};
      end
    end
  end

endmodule

// ==== verilog/iopmp_tl_responder.sv ====
module iopmp_tl_responder (
  input  logic                     clk,
  input  logic                     reset,
  reg_access_if.bank               acc,
  input  iopmp_tl_pkg::tl_source_t a_source_i,
  input  iopmp_tl_pkg::tl_data_t   cfg_rdata_i,
  input  iopmp_tl_pkg::tl_data_t   tbl_rdata_i,
  input  logic                     d_ready_i,
  output logic                     a_ready_o,
  output logic                     d_valid_o,
  output iopmp_tl_pkg::tl_d_op_e   d_opcode_o,
  output iopmp_tl_pkg::tl_source_t d_source_o,
  output iopmp_tl_pkg::tl_data_t   d_data_o
);
  import iopmp_tl_pkg::*;
  import iopmp_reg_pkg::*;

  resp_state_e state_q;
  tl_d_op_e opcode_q;
  tl_source_t source_q;
  tl_data_t data_q;

  // one request in flight, A side blocked while answering
  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE: if (acc.access) state_q <= RESP;
        RESP: if (d_ready_i) state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  // response fields, held stable through a stall
  always_ff @(posedge clk) begin
    if (acc.access) begin
      opcode_q <= acc.write ? AccessAck : AccessAckData;
      source_q <= a_source_i;
      data_q <= acc.write ? '0 : (cfg_rdata_i | tbl_rdata_i);
    end
  end

  assign a_ready_o = (state_q == IDLE);
  assign d_valid_o = (state_q == RESP);
  assign d_opcode_o = opcode_q;
  assign d_source_o = source_q;
  assign d_data_o = data_q;

endmodule

// ==== verilog/iopmp_control_port.sv ====
`include "iopmp_params.svh"

module iopmp_control_port (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      a_valid_i,
  input  iopmp_tl_pkg::tl_a_op_e    a_opcode_i,
  input  iopmp_tl_pkg::tl_addr_t    a_address_i,
  input  iopmp_tl_pkg::tl_source_t  a_source_i,
  input  iopmp_tl_pkg::tl_data_t    a_data_i,
  output logic                      a_ready_o,
  output logic                      d_valid_o,
  output iopmp_tl_pkg::tl_d_op_e    d_opcode_o,
  output iopmp_tl_pkg::tl_source_t  d_source_o,
  output iopmp_tl_pkg::tl_data_t    d_data_o,
  input  logic                      d_ready_i,
  output iopmp_tl_pkg::tl_data_t    entry_addr_o [`IOPMP_ENTRIES],
  output iopmp_reg_pkg::entry_cfg_t entry_cfg_o [`IOPMP_ENTRIES],
  output iopmp_reg_pkg::entry_num_t mdcfg_o [`IOPMP_MDS],
  output iopmp_tl_pkg::tl_data_t    srcmd_en_o [`IOPMP_RRIDS],
  output iopmp_reg_pkg::entry_num_t prio_entry_o,
  output logic                      enable_o
);
  import iopmp_tl_pkg::*;
  import iopmp_reg_pkg::*;

  tl_data_t cfg_rdata;
  tl_data_t tbl_rdata;
  entry_num_t mdcfglck_f;
  entry_num_t entrylck_f;

  reg_access_if u_acc ();

  //////////////////////////////
  // request side
  //////////////////////////////

  iopmp_addr_decoder u_addr_decoder (
    .a_valid_i   (a_valid_i),
    .a_opcode_i  (a_opcode_i),
    .a_address_i (a_address_i),
    .a_data_i    (a_data_i),
    .a_ready_i   (a_ready_o),
    .acc         (u_acc.dec)
  );

  // global and lock registers
  iopmp_cfg_regs u_cfg_regs (
    .clk          (clk),
    .reset        (reset),
    .acc          (u_acc.bank),
    .cfg_rdata_o  (cfg_rdata),
    .mdcfglck_f_o (mdcfglck_f),
    .entrylck_f_o (entrylck_f),
    .prio_entry_o (prio_entry_o),
    .enable_o     (enable_o)
  );

  iopmp_table_regs u_table_regs (
    .clk          (clk),
    .reset        (reset),
    .acc          (u_acc.bank),
    .mdcfglck_f_i (mdcfglck_f),
    .entrylck_f_i (entrylck_f),
    .tbl_rdata_o  (tbl_rdata),
    .entry_addr_o (entry_addr_o),
    .entry_cfg_o  (entry_cfg_o),
    .mdcfg_o      (mdcfg_o),
    .srcmd_en_o   (srcmd_en_o)
  );

  //////////////////////////////
  // response side
  //////////////////////////////

  iopmp_tl_responder u_tl_responder (
    .clk         (clk),
    .reset       (reset),
    .acc         (u_acc.bank),
    .a_source_i  (a_source_i),
    .cfg_rdata_i (cfg_rdata),
    .tbl_rdata_i (tbl_rdata),
    .d_ready_i   (d_ready_i),
    .a_ready_o   (a_ready_o),
    .d_valid_o   (d_valid_o),
    .d_opcode_o  (d_opcode_o),
    .d_source_o  (d_source_o),
    .d_data_o    (d_data_o)
  );

endmodule

// ==== test/iopmp_tb.sv ====
`include "iopmp_params.svh"

module iopmp_tb;
  import iopmp_tl_pkg::*;
  import iopmp_reg_pkg::*;

  // requests issued by the test sequence below
  localparam int NUM_TXNS = 82;

  logic clk;
  logic reset;
  logic a_valid_i;
  tl_a_op_e a_opcode_i;
  tl_addr_t a_address_i;
  tl_source_t a_source_i;
  tl_data_t a_data_i;
  logic a_ready_o;
  logic d_valid_o;
  tl_d_op_e d_opcode_o;
  tl_source_t d_source_o;
  tl_data_t d_data_o;
  logic d_ready_i;
  tl_data_t entry_addr_o [`IOPMP_ENTRIES];
  entry_cfg_t entry_cfg_o [`IOPMP_ENTRIES];
  entry_num_t mdcfg_o [`IOPMP_MDS];
  tl_data_t srcmd_en_o [`IOPMP_RRIDS];
  entry_num_t prio_entry_o;
  logic enable_o;

  int errors;

  // shadow state of the register file
  bit m_enable;
  bit m_prient_prog;
  entry_num_t m_prio;
  bit m_mlck_l;
  logic [6:0] m_mlck_f;
  bit m_elck_l;
  entry_num_t m_elck_f;
  entry_num_t m_mdcfg [`IOPMP_MDS];
  tl_data_t m_srcmd [`IOPMP_RRIDS];
  tl_data_t m_eaddr [`IOPMP_ENTRIES];
  entry_cfg_t m_ecfg [`IOPMP_ENTRIES];

  // expected responses in order of acceptance
  tl_d_op_e exp_op [$];
  tl_source_t exp_src [$];
  tl_data_t exp_data [$];

  // expected responder state
  logic resp_exp;

  iopmp_control_port u_iopmp_control_port (
    .clk          (clk),
    .reset        (reset),
    .a_valid_i    (a_valid_i),
    .a_opcode_i   (a_opcode_i),
    .a_address_i  (a_address_i),
    .a_source_i   (a_source_i),
    .a_data_i     (a_data_i),
    .a_ready_o    (a_ready_o),
    .d_valid_o    (d_valid_o),
    .d_opcode_o   (d_opcode_o),
    .d_source_o   (d_source_o),
    .d_data_o     (d_data_o),
    .d_ready_i    (d_ready_i),
    .entry_addr_o (entry_addr_o),
    .entry_cfg_o  (entry_cfg_o),
    .mdcfg_o      (mdcfg_o),
    .srcmd_en_o   (srcmd_en_o),
    .prio_entry_o (prio_entry_o),
    .enable_o     (enable_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////
  // compare tasks
  //////////////////////////////

  task automatic chk_data(input string name, input tl_data_t exp, input tl_data_t act);
    if (act !== exp) begin
      $display("ERR %0t %s exp=%h act=%h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic chk_opcode(input string name, input tl_d_op_e exp, input tl_d_op_e act);
    if (act !== exp) begin
      $display("ERR %0t %s exp=%0d act=%0d", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic chk_source(input string name, input tl_source_t exp, input tl_source_t act);
    if (act !== exp) begin
      $display("ERR %0t %s exp=%h act=%h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic chk_num(input string name, input entry_num_t exp, input entry_num_t act);
    if (act !== exp) begin
      $display("ERR %0t %s exp=%h act=%h", $time, name, exp, act);
      errors++;
    end
  endtask

  //////////////////////////////
  // reference model
  //////////////////////////////

  // index of the table slot hit by addr or -1 when none
  function automatic int slot_of(tl_addr_t addr, int base, int stride, int count);
    for (int k = 0; k < count; k++) begin
      if (addr == tl_addr_t'(base + k * stride)) return k;
    end
    return -1;
  endfunction

  function automatic void model_reset();
    m_enable = 1'b0;
    m_prient_prog = 1'b1;
    m_prio = '0;
    m_mlck_l = 1'b0;
    m_mlck_f = '0;
    m_elck_l = 1'b0;
    m_elck_f = '0;
    foreach (m_mdcfg[j]) m_mdcfg[j] = '0;
    foreach (m_srcmd[j]) m_srcmd[j] = '0;
    foreach (m_eaddr[i]) m_eaddr[i] = '0;
    foreach (m_ecfg[i]) m_ecfg[i] = '0;
  endfunction

  function automatic void model_write(tl_addr_t addr, tl_data_t d);
    int k;
    case (addr)
      `OFS_HWCFG0: begin
        if (d[31]) m_enable = 1'b1;
        if (d[7]) m_prient_prog = 1'b0;
      end
      `OFS_HWCFG2: begin
        if (m_prient_prog && d[15:0] < `IOPMP_ENTRIES) m_prio = d[15:0];
      end
      `OFS_MDCFGLCK: begin
        // f uses the lock bit as it was before this write
        if (!m_mlck_l) m_mlck_f = d[7:1];
        if (d[0]) m_mlck_l = 1'b1;
      end
      `OFS_ENTRYLCK: begin
        if (!m_elck_l && d[16:1] >= m_elck_f && d[16:1] <= `IOPMP_ENTRIES) m_elck_f = d[16:1];
        if (d[0]) m_elck_l = 1'b1;
      end
      default: begin
        k = slot_of(addr, `OFS_MDCFG, `MDCFG_STRIDE, `IOPMP_MDS);
        if (k >= 0 && k >= m_mlck_f && d[15:0] <= `IOPMP_ENTRIES &&
            (k == 0 || d[15:0] >= m_mdcfg[k-1])) m_mdcfg[k] = d[15:0];
        k = slot_of(addr, `OFS_SRCMD, `SRCMD_STRIDE, `IOPMP_RRIDS);
        if (k >= 0) begin
          if (!m_srcmd[k][0]) m_srcmd[k][31:1] = d[31:1];
          if (d[0]) m_srcmd[k][0] = 1'b1;
        end
        k = slot_of(addr, `OFS_ENTRY, `ENTRY_STRIDE, `IOPMP_ENTRIES);
        if (k >= 0 && k >= m_elck_f) m_eaddr[k] = d;
        k = slot_of(addr, `OFS_ENTRY + `ENTRY_CFG_SUB, `ENTRY_STRIDE, `IOPMP_ENTRIES);
        if (k >= 0 && k >= m_elck_f) m_ecfg[k] = d[10:0];
      end
    endcase
  endfunction

  function automatic tl_data_t ref_read(tl_addr_t addr);
    int k;
    case (addr)
      `OFS_VERSION: return {8'h0, `IOPMP_VENDOR};
      `OFS_IMPL: return `IOPMP_IMPID;
      `OFS_HWCFG0: return {m_enable, 7'(`IOPMP_MDS), 16'h0, m_prient_prog, 2'b00, 1'b1,
                           `IOPMP_MODEL};
      `OFS_HWCFG1: return (32'(`IOPMP_ENTRIES) << 16) | 32'(`IOPMP_RRIDS);
      `OFS_HWCFG2: return {16'h0, m_prio};
      `OFS_ENTRYOFFSET: return {16'h0, `OFS_ENTRY};
      `OFS_MDCFGLCK: return {24'h0, m_mlck_f, m_mlck_l};
      `OFS_ENTRYLCK: return {15'h0, m_elck_f, m_elck_l};
      default: ;
    endcase
    k = slot_of(addr, `OFS_MDCFG, `MDCFG_STRIDE, `IOPMP_MDS);
    if (k >= 0) return {16'h0, m_mdcfg[k]};
    k = slot_of(addr, `OFS_SRCMD, `SRCMD_STRIDE, `IOPMP_RRIDS);
    if (k >= 0) return m_srcmd[k];
    k = slot_of(addr, `OFS_ENTRY, `ENTRY_STRIDE, `IOPMP_ENTRIES);
    if (k >= 0) return m_eaddr[k];
    k = slot_of(addr, `OFS_ENTRY + `ENTRY_CFG_SUB, `ENTRY_STRIDE, `IOPMP_ENTRIES);
    if (k >= 0) return {21'h0, m_ecfg[k]};
    return '0;
  endfunction

  //////////////////////////////
  // bus tasks
  //////////////////////////////

  // one request followed by a random d_ready_i hold-off of 0 to 3 cycles
  task automatic bus_req(input tl_a_op_e op, input tl_addr_t addr, input tl_data_t data);
    int stall;
    tl_source_t src;
    stall = $urandom_range(0, 3);
    src = tl_source_t'($urandom);
    a_valid_i = 1'b1;
    a_opcode_i = op;
    a_address_i = addr;
    a_source_i = src;
    a_data_i = data;
    @(posedge clk);
    while (!a_ready_o) @(posedge clk);
    exp_src.push_back(src);
    if (op == Get) begin
      exp_op.push_back(AccessAckData);
      exp_data.push_back(ref_read(addr));
    end else begin
      exp_op.push_back(AccessAck);
      exp_data.push_back('0);
      model_write(addr, data);
    end
    #1;
    a_valid_i = 1'b0;
    if (stall > 0) begin
      repeat (stall) @(posedge clk);
      #1;
    end
    d_ready_i = 1'b1;
    @(posedge clk);
    while (!d_valid_o) @(posedge clk);
    #1;
    d_ready_i = 1'b0;
  endtask

  task automatic bus_write(input tl_addr_t addr, input tl_data_t data);
    bus_req(PutFullData, addr, data);
  endtask

  task automatic bus_read(input tl_addr_t addr);
    bus_req(Get, addr, '0);
  endtask

  task automatic check_outputs();
    for (int i = 0; i < `IOPMP_ENTRIES; i++) begin
      chk_data($sformatf("entry_addr_o[%0d]", i), m_eaddr[i], entry_addr_o[i]);
      chk_num($sformatf("entry_cfg_o[%0d]", i), entry_num_t'(m_ecfg[i]),
              entry_num_t'(entry_cfg_o[i]));
    end
    for (int j = 0; j < `IOPMP_MDS; j++) begin
      chk_num($sformatf("mdcfg_o[%0d]", j), m_mdcfg[j], mdcfg_o[j]);
    end
    for (int j = 0; j < `IOPMP_RRIDS; j++) begin
      chk_data($sformatf("srcmd_en_o[%0d]", j), m_srcmd[j], srcmd_en_o[j]);
    end
    chk_num("prio_entry_o", m_prio, prio_entry_o);
    chk_data("enable_o", tl_data_t'(m_enable), tl_data_t'(enable_o));
  endtask

  //////////////////////////////
  // response checker
  //////////////////////////////

  always @(posedge clk) begin
    if (reset) begin
      resp_exp = 1'b0;
    end else begin
      chk_data("a_ready_o", tl_data_t'(!resp_exp), tl_data_t'(a_ready_o));
      chk_data("d_valid_o", tl_data_t'(resp_exp), tl_data_t'(d_valid_o));
      if (resp_exp) begin
        // fields match the expected response on every cycle of a stall
        if (exp_op.size() == 0) begin
          $display("response at %0t with no request outstanding", $time);
          errors++;
        end else begin
          chk_opcode("d_opcode_o", exp_op[0], d_opcode_o);
          chk_source("d_source_o", exp_src[0], d_source_o);
          chk_data("d_data_o", exp_data[0], d_data_o);
          if (d_ready_i) begin
            exp_op.delete(0);
            exp_src.delete(0);
            exp_data.delete(0);
          end
        end
        resp_exp = !d_ready_i;
      end else begin
        resp_exp = a_valid_i;
      end
    end
  end

  initial begin
    repeat (NUM_TXNS * 20 + 200) @(posedge clk);
    $display("timeout, the test sequence did not finish in time (%0d errors so far)", errors);
    $display("Test FAILED");
    $finish;
  end

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial begin
    void'($urandom(32'h8e2f_c944));
    errors = 0;
    reset = 1'b1;
    a_valid_i = 1'b0;
    a_opcode_i = Get;
    a_address_i = '0;
    a_source_i = '0;
    a_data_i = '0;
    d_ready_i = 1'b0;
    model_reset();
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;

    // identity registers and sticky enable
    bus_read(`OFS_VERSION);
    bus_read(`OFS_IMPL);
    bus_read(`OFS_HWCFG0);
    bus_read(`OFS_HWCFG1);
    bus_read(`OFS_ENTRYOFFSET);
    bus_write(`OFS_HWCFG0, 32'h8000_0000);
    bus_write(`OFS_HWCFG0, 32'h0);
    bus_read(`OFS_HWCFG0);
    check_outputs();

    // prio_entry before and after clearing prient_prog
    bus_write(`OFS_HWCFG2, 32'd2);
    bus_read(`OFS_HWCFG2);
    bus_write(`OFS_HWCFG2, 32'(`IOPMP_ENTRIES));
    bus_read(`OFS_HWCFG2);
    bus_write(`OFS_HWCFG0, 32'h80);
    bus_write(`OFS_HWCFG2, 32'd1);
    bus_read(`OFS_HWCFG2);
    bus_read(`OFS_HWCFG0);
    check_outputs();

    // entry table before and after locking below entry 2
    for (int i = 0; i < `IOPMP_ENTRIES; i++) begin
      bus_write(tl_addr_t'(`OFS_ENTRY + i * `ENTRY_STRIDE), $urandom);
      bus_write(tl_addr_t'(`OFS_ENTRY + i * `ENTRY_STRIDE + `ENTRY_CFG_SUB), $urandom);
    end
    for (int i = 0; i < `IOPMP_ENTRIES; i++) begin
      bus_read(tl_addr_t'(`OFS_ENTRY + i * `ENTRY_STRIDE));
      bus_read(tl_addr_t'(`OFS_ENTRY + i * `ENTRY_STRIDE + `ENTRY_CFG_SUB));
    end
    check_outputs();
    bus_write(`OFS_ENTRYLCK, 32'd2 << 1);
    bus_read(`OFS_ENTRYLCK);
    for (int i = 0; i < `IOPMP_ENTRIES; i++) begin
      bus_write(tl_addr_t'(`OFS_ENTRY + i * `ENTRY_STRIDE), $urandom);
      bus_write(tl_addr_t'(`OFS_ENTRY + i * `ENTRY_STRIDE + `ENTRY_CFG_SUB), $urandom);
      bus_read(tl_addr_t'(`OFS_ENTRY + i * `ENTRY_STRIDE));
      bus_read(tl_addr_t'(`OFS_ENTRY + i * `ENTRY_STRIDE + `ENTRY_CFG_SUB));
    end
    check_outputs();
    bus_write(`OFS_ENTRYLCK, 32'h5);
    bus_write(`OFS_ENTRYLCK, 32'd4 << 1);
    bus_read(`OFS_ENTRYLCK);

    // MDCFG ordering and domain lock
    bus_write(`OFS_MDCFG, 32'd5);
    bus_write(`OFS_MDCFG, 32'd2);
    bus_write(`OFS_MDCFG + `MDCFG_STRIDE, 32'd1);
    bus_write(`OFS_MDCFG + `MDCFG_STRIDE, 32'd3);
    bus_read(`OFS_MDCFG);
    bus_read(`OFS_MDCFG + `MDCFG_STRIDE);
    bus_write(`OFS_MDCFGLCK, 32'd1 << 1);
    bus_write(`OFS_MDCFG, 32'd1);
    bus_write(`OFS_MDCFG + `MDCFG_STRIDE, 32'd4);
    bus_read(`OFS_MDCFG);
    bus_read(`OFS_MDCFG + `MDCFG_STRIDE);
    check_outputs();

    // SRCMD_EN up to and past its lock
    for (int j = 0; j < `IOPMP_RRIDS; j++) begin
      bus_write(tl_addr_t'(`OFS_SRCMD + j * `SRCMD_STRIDE), $urandom & 32'hFFFF_FFFE);
      bus_read(tl_addr_t'(`OFS_SRCMD + j * `SRCMD_STRIDE));
      bus_write(tl_addr_t'(`OFS_SRCMD + j * `SRCMD_STRIDE), $urandom | 32'h1);
      bus_read(tl_addr_t'(`OFS_SRCMD + j * `SRCMD_STRIDE));
      bus_write(tl_addr_t'(`OFS_SRCMD + j * `SRCMD_STRIDE), $urandom);
      bus_read(tl_addr_t'(`OFS_SRCMD + j * `SRCMD_STRIDE));
    end
    check_outputs();

    // unmapped and read-only addresses
    bus_read(16'h0018);
    bus_read(`OFS_MDCFG + 2 * `MDCFG_STRIDE);
    bus_read(`OFS_ENTRY + 16'h4);
    bus_read(`OFS_SRCMD + 2 * `SRCMD_STRIDE);
    bus_write(`OFS_VERSION, 32'hFFFF_FFFF);
    bus_read(`OFS_VERSION);
    check_outputs();

    repeat (2) @(posedge clk);
    if (exp_op.size() != 0) begin
      $display("%0d responses never arrived", exp_op.size());
      errors++;
    end
    $display("checks done, %0d errors", errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+verilog
verilog/iopmp_tl_pkg.sv
verilog/iopmp_reg_pkg.sv
verilog/iopmp_reg_if.sv
verilog/iopmp_addr_decoder.sv
verilog/iopmp_cfg_regs.sv
verilog/iopmp_table_regs.sv
verilog/iopmp_tl_responder.sv
verilog/iopmp_control_port.sv
test/iopmp_tb.sv
